// ==== Bender.yml ====
package:
  name: uart_ctrl

sources:
  - design/uart_frame_pkg.sv
  - design/uart_fsm_pkg.sv
  - design/baud_tick_gen.sv
  - design/rx_sampler.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/uart_ctrl.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_uart_ctrl.sv

// ==== design/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen import uart_frame_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  clk_div_t clock_divider,
  output logic     tick
);

  clk_div_t count;

  assign tick = (count == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;  // first tick right after reset
    end else if (tick) begin
      count <= clock_divider;
    end else begin
      count <= count - 1'b1;
    end
  end

  // reload of a nonzero divider must leave a gap
  tick_no_repeat: assert property (@(posedge clk) disable iff (reset)
    tick && (clock_divider != '0) |=> !tick);

endmodule

// ==== design/rx_sampler.sv ====
`timescale 1ns/1ps

module rx_sampler import uart_frame_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic rxd,
  input  logic tick,
  output logic sample_value,
  output logic sample_tick
);

  logic [1:0]                        sync_q;
  logic [SAMPLE_DEPTH-2:0]           history;
  logic [SAMPLE_DEPTH-1:0]           samples;
  logic [$clog2(SAMPLE_DEPTH+1)-1:0] ones;

  // two-flop synchroniser, idle line reads high
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rxd};
    end
  end

  assign samples = {history, sync_q[1]};

  always_comb begin
    ones = '0;
    for (int i = 0; i < SAMPLE_DEPTH; i++) begin
      ones = ones + samples[i];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      history      <= '1;
      sample_value <= 1'b1;
      sample_tick  <= 1'b0;
    end else begin
      if (tick) begin
        history <= {history[SAMPLE_DEPTH-3:0], sync_q[1]};
      end
      sample_value <= (ones > SAMPLE_DEPTH / 2);  // majority vote
      sample_tick  <= tick;  // lines up with the vote
    end
  end

endmodule

// ==== design/uart_ctrl.sv ====
`timescale 1ns/1ps

module uart_ctrl import uart_frame_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  clk_div_t   clock_divider,
  input  data_len_t  data_len,
  input  parity_t    parity,
  input  stop_t      stop,
  input  logic       rxd,
  output logic       txd,
  input  logic       write_req,
  input  uart_byte_t write_data,
  output logic       write_ack,
  output logic       read_req,
  output uart_byte_t read_data,
  input  logic       read_ack,
  output logic       frame_error,
  output logic       overrun
);

  logic tick;          // eight per bit
  logic sample_value;
  logic sample_tick;

  baud_tick_gen baud_tick_gen_i (
    .clk           (clk),
    .reset         (reset),
    .clock_divider (clock_divider),
    .tick          (tick)
  );

  rx_sampler rx_sampler_i (
    .clk          (clk),
    .reset        (reset),
    .rxd          (rxd),
    .tick         (tick),
    .sample_value (sample_value),
    .sample_tick  (sample_tick)
  );

  uart_rx uart_rx_i (
    .clk          (clk),
    .reset        (reset),
    .data_len     (data_len),
    .parity       (parity),
    .stop         (stop),
    .sample_value (sample_value),
    .sample_tick  (sample_tick),
    .read_req     (read_req),
    .read_data    (read_data),
    .read_ack     (read_ack),
    .frame_error  (frame_error),
    .overrun      (overrun)
  );

  uart_tx uart_tx_i (
    .clk        (clk),
    .reset      (reset),
    .data_len   (data_len),
    .parity     (parity),
    .stop       (stop),
    .tick       (tick),
    .write_req  (write_req),
    .write_data (write_data),
    .write_ack  (write_ack),
    .txd        (txd)
  );

endmodule

// ==== design/uart_frame_pkg.sv ====
package uart_frame_pkg;

  localparam int OVERSAMPLE   = 8;  // ticks per bit
  localparam int SAMPLE_DEPTH = 5;  // majority vote window
  localparam int START_OFFSET = 2;  // puts sampling near mid-bit
  localparam int BIT_TIMER_W  = 3;

  typedef enum logic [1:0] {
    PARITY_NONE = 2'b00,
    PARITY_EVEN = 2'b01,
    PARITY_ODD  = 2'b10
  } parity_t;

  typedef enum logic {
    STOP_ONE = 1'b0,
    STOP_TWO = 1'b1
  } stop_t;

  // data bits minus one, 4 to 7 legal
  typedef logic [2:0] data_len_t;

  // upper bits zero in short frames
  typedef logic [7:0] uart_byte_t;

  // one tick every value + 1 cycles
  typedef logic [19:0] clk_div_t;

endpackage

// ==== design/uart_fsm_pkg.sv ====
package uart_fsm_pkg;

  // shared by the rx and tx frame FSMs
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_START  = 3'd1,
    ST_DATA   = 3'd2,
    ST_PARITY = 3'd3,
    ST_STOP   = 3'd4
  } uart_state_t;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_frame_pkg::*, uart_fsm_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  data_len_t  data_len,
  input  parity_t    parity,
  input  stop_t      stop,
  input  logic       sample_value,
  input  logic       sample_tick,
  output logic       read_req,
  output uart_byte_t read_data,
  input  logic       read_ack,
  output logic       frame_error,
  output logic       overrun
);

  uart_state_t            state;
  logic [BIT_TIMER_W-1:0] bit_timer;
  logic                   bit_tick;
  logic                   start_seen;
  logic [2:0]             bit_cnt;
  logic [2:0]             last_stop;
  logic                   parity_acc;
  uart_byte_t             shifter;
  logic                   read_busy;
  logic                   frame_done;
  logic                   deliver;

  assign start_seen = (state == ST_IDLE) && sample_tick && !sample_value;
  assign bit_tick   = sample_tick && (bit_timer == '0);
  assign last_stop  = (stop == STOP_TWO) ? 3'd1 : 3'd0;

  // last stop bit read high, frame is good
  assign frame_done = (state == ST_STOP) && bit_tick && sample_value &&
                      (bit_cnt == last_stop);
  assign deliver    = frame_done && !read_busy;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      bit_timer <= '0;
    end else if (start_seen) begin
      bit_timer <= BIT_TIMER_W'(START_OFFSET);
    end else if (bit_tick) begin
      bit_timer <= BIT_TIMER_W'(OVERSAMPLE - 1);
    end else if (sample_tick) begin
      bit_timer <= bit_timer - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ST_IDLE;
      bit_cnt     <= '0;
      frame_error <= 1'b0;
      overrun     <= 1'b0;
      read_req    <= 1'b0;
      read_busy   <= 1'b0;
    end else begin
      frame_error <= 1'b0;
      overrun     <= 1'b0;
      if (read_req && read_ack) begin
        read_req <= 1'b0;
      end
      if (!read_req && !read_ack) begin
        read_busy <= 1'b0;  // host has closed the handshake
      end
      case (state)
        ST_IDLE: begin
          if (start_seen) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          if (bit_tick) begin
            bit_cnt <= '0;
            state   <= sample_value ? ST_IDLE : ST_DATA;  // false start
          end
        end
        ST_DATA: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == data_len) begin
              bit_cnt <= '0;
              state   <= (parity == PARITY_NONE) ? ST_STOP : ST_PARITY;
            end
          end
        end
        ST_PARITY: begin
          if (bit_tick) begin
            if (parity_acc == sample_value) begin
              state <= ST_STOP;
            end else begin
              frame_error <= 1'b1;
              state       <= ST_IDLE;
            end
          end
        end
        ST_STOP: begin
          if (bit_tick) begin
            if (!sample_value) begin
              frame_error <= 1'b1;
              state       <= ST_IDLE;
            end else if (frame_done) begin
              state <= ST_IDLE;
              if (read_busy) begin
                overrun <= 1'b1;  // previous byte still out
              end else begin
                read_req  <= 1'b1;
                read_busy <= 1'b1;
              end
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_START && bit_tick) begin
      shifter    <= '0;
      parity_acc <= (parity == PARITY_ODD);
    end else if (state == ST_DATA && bit_tick) begin
      shifter[bit_cnt] <= sample_value;  // lsb first
      parity_acc       <= parity_acc ^ sample_value;
    end
    if (deliver) begin
      read_data <= shifter;
    end
  end

  read_data_stable: assert property (@(posedge clk) disable iff (reset)
    read_req && $past(read_req) |-> $stable(read_data));

  read_req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(read_req) |-> $past(read_ack));

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import uart_frame_pkg::*, uart_fsm_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  data_len_t  data_len,
  input  parity_t    parity,
  input  stop_t      stop,
  input  logic       tick,
  input  logic       write_req,
  input  uart_byte_t write_data,
  output logic       write_ack,
  output logic       txd
);

  uart_state_t            state;
  logic [BIT_TIMER_W-1:0] tick_cnt;
  logic                   wrap;
  logic [2:0]             bit_cnt;
  logic [2:0]             last_stop;
  logic                   pending;
  logic                   launch;
  logic                   parity_acc;
  uart_byte_t             data_reg;
  logic                   txd_next;

  assign wrap      = tick && (tick_cnt == BIT_TIMER_W'(OVERSAMPLE - 1));
  assign pending   = write_req && !write_ack;
  assign last_stop = (stop == STOP_TWO) ? 3'd1 : 3'd0;

  // start from idle, or straight after the last stop bit
  assign launch = wrap && pending &&
                  ((state == ST_IDLE) || (state == ST_STOP && bit_cnt == last_stop));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= wrap ? '0 : tick_cnt + 1'b1;
    end
  end

  always_comb begin
    case (state)
      ST_START:  txd_next = 1'b0;
      ST_DATA:   txd_next = data_reg[bit_cnt];
      ST_PARITY: txd_next = parity_acc;
      default:   txd_next = 1'b1;  // idle and stop
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ST_IDLE;
      bit_cnt   <= '0;
      write_ack <= 1'b0;
      txd       <= 1'b1;
    end else begin
      txd <= txd_next;
      if (write_ack && !write_req) begin
        write_ack <= 1'b0;
      end
      if (launch) begin
        write_ack <= 1'b1;
        state     <= ST_START;
      end else if (wrap) begin
        case (state)
          ST_START: begin
            bit_cnt <= '0;
            state   <= ST_DATA;
          end
          ST_DATA: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == data_len) begin
              bit_cnt <= '0;
              state   <= (parity == PARITY_NONE) ? ST_STOP : ST_PARITY;
            end
          end
          ST_PARITY: begin
            bit_cnt <= '0;
            state   <= ST_STOP;
          end
          ST_STOP: begin
            if (bit_cnt == last_stop) begin
              state <= ST_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      data_reg <= write_data;
    end
    if (wrap && state == ST_START) begin
      parity_acc <= (parity == PARITY_ODD);  // odd seeds with one
    end else if (wrap && state == ST_DATA) begin
      parity_acc <= parity_acc ^ data_reg[bit_cnt];
    end
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(write_ack) |-> $past(write_req));

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== dv/tb_uart_ctrl.sv ====
`timescale 1ns/1ps

module tb_uart_ctrl import uart_frame_pkg::*; ();

  localparam int SIG_ACK  = 0;
  localparam int SIG_REQ  = 1;
  localparam int SIG_TXD  = 2;
  localparam int SIG_FERR = 3;
  localparam int SIG_OVR  = 4;
  localparam int SIG_RST  = 5;

  logic       clk;
  logic       reset;
  clk_div_t   clock_divider;
  data_len_t  data_len;
  parity_t    parity;
  stop_t      stop;
  logic       rxd;
  logic       txd;
  logic       write_req;
  uart_byte_t write_data;
  logic       write_ack;
  logic       read_req;
  uart_byte_t read_data;
  logic       read_ack;
  logic       frame_error;
  logic       overrun;

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  uart_ctrl dut_i (
    .clk           (clk),
    .reset         (reset),
    .clock_divider (clock_divider),
    .data_len      (data_len),
    .parity        (parity),
    .stop          (stop),
    .rxd           (rxd),
    .txd           (txd),
    .write_req     (write_req),
    .write_data    (write_data),
    .write_ack     (write_ack),
    .read_req      (read_req),
    .read_data     (read_data),
    .read_ack      (read_ack),
    .frame_error   (frame_error),
    .overrun       (overrun)
  );

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("Fail at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic logic signal_value(input int sel);
    case (sel)
      SIG_ACK:  return write_ack;
      SIG_REQ:  return read_req;
      SIG_TXD:  return txd;
      SIG_FERR: return frame_error;
      SIG_OVR:  return overrun;
      default:  return reset;
    endcase
  endfunction

  // polls on falling edges so the DUT outputs are settled
  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what);
    for (int n = 0; n < limit; n++) begin
      @(negedge clk);
      if (signal_value(sel) === level) begin
        return;
      end
    end
    $display("timeout after %0d cycles waiting for %s", limit, what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic stay_low(input int sel, input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk);
      check(signal_value(sel), 0, what);
    end
  endtask

  function automatic uart_byte_t mask_data(input uart_byte_t data, input int bits);
    return data & uart_byte_t'((1 << bits) - 1);
  endfunction

  // even makes the one count even, odd makes it odd
  function automatic logic parity_bit(input uart_byte_t data, input int bits, input int par);
    logic ones;
    ones = ^mask_data(data, bits);
    return (par == 2) ? ~ones : ones;
  endfunction

  task automatic send_bit(input logic value, input int cyc);
    @(posedge clk);
    rxd <= value;
    repeat (cyc - 1) @(posedge clk);
  endtask

  task automatic send_frame(input uart_byte_t data, input int bits, input int par,
                            input int stops, input int cyc, input logic bad_par,
                            input logic bad_stop);
    send_bit(1'b0, cyc);
    for (int i = 0; i < bits; i++) begin
      send_bit(data[i], cyc);  // lsb first
    end
    if (par != 0) begin
      send_bit(parity_bit(data, bits, par) ^ bad_par, cyc);
    end
    for (int i = 0; i < stops; i++) begin
      if (bad_stop && i == stops - 1) begin
        // low past mid-bit only, so it cannot pass as a new start bit
        @(posedge clk);
        rxd <= 1'b0;
        repeat (cyc * 6 / 8 - 1) @(posedge clk);
        send_bit(1'b1, cyc * 2 / 8);
      end else begin
        send_bit(1'b1, cyc);
      end
    end
    send_bit(1'b1, 2 * cyc);
  endtask

  task automatic read_handshake();
    @(posedge clk);
    read_ack <= 1'b1;
    wait_level(SIG_REQ, 1'b0, 16, "read_req to fall after read_ack");
    @(posedge clk);
    read_ack <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic run_tx(input uart_byte_t data, input int bits, input int par,
                        input int stops, input int cyc);
    @(posedge clk);
    write_data <= data;
    write_req  <= 1'b1;
    wait_level(SIG_ACK, 1'b1, 3 * cyc, "write_ack to rise");
    @(posedge clk);
    write_req <= 1'b0;
    wait_level(SIG_TXD, 1'b0, 2 * cyc, "txd start edge");
    repeat (cyc / 2) @(negedge clk);
    check(txd, 0, "tx start bit");
    for (int i = 0; i < bits; i++) begin
      repeat (cyc) @(negedge clk);
      check(txd, data[i], "tx data bit");
    end
    if (par != 0) begin
      repeat (cyc) @(negedge clk);
      check(txd, parity_bit(data, bits, par), "tx parity bit");
    end
    for (int i = 0; i < stops; i++) begin
      repeat (cyc) @(negedge clk);
      check(txd, 1, "tx stop bit");
    end
    check(write_ack, 0, "write_ack low after write_req dropped");
    repeat (2 * cyc) @(posedge clk);
  endtask

  task automatic run_rx(input uart_byte_t data, input int bits, input int par,
                        input int stops, input int cyc, input int op);
    int frame_cyc;
    frame_cyc = (1 + bits + (par != 0) + stops) * cyc;
    if (op == 2 || op == 3) begin
      fork
        send_frame(data, bits, par, stops, cyc, op == 2, op == 3);
        wait_level(SIG_FERR, 1'b1, 2 * frame_cyc, "frame_error pulse");
        stay_low(SIG_REQ, frame_cyc + 2 * cyc, "read_req after bad frame");
      join
    end else begin
      fork
        send_frame(data, bits, par, stops, cyc, 1'b0, 1'b0);
        wait_level(SIG_REQ, 1'b1, 2 * frame_cyc, "read_req to rise");
      join
      @(negedge clk);
      check(read_req, 1, "read_req held until read_ack");
      check(read_data, mask_data(data, bits), "rx read_data");
      if (op == 4) begin
        fork
          send_frame(data ^ 8'hff, bits, par, stops, cyc, 1'b0, 1'b0);
          wait_level(SIG_OVR, 1'b1, 2 * frame_cyc, "overrun pulse");
        join
        @(negedge clk);
        check(read_req, 1, "read_req held during overrun");
        check(read_data, mask_data(data, bits), "read_data kept after overrun");
      end
      read_handshake();
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          cyc;
    logic [31:0] div_v;
    logic [31:0] bits_v;
    logic [31:0] par_v;
    logic [31:0] stop_v;
    logic [31:0] op_v;
    logic [31:0] data_v;
    reg [1023:0] line;
    clock_divider = 20'd3;
    data_len      = 3'd7;
    parity        = PARITY_NONE;
    stop          = STOP_ONE;
    rxd           = 1'b1;
    write_req     = 1'b0;
    write_data    = '0;
    read_ack      = 1'b0;
    fd = $fopen("dv/uart_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file dv/uart_stim.txt");
      $display("test failed");
      $fatal(1);
    end
    wait_level(SIG_RST, 1'b0, 20, "reset release");
    check(txd, 1, "txd idle after reset");
    check(write_ack, 0, "write_ack after reset");
    check(read_req, 0, "read_req after reset");
    check(frame_error, 0, "frame_error after reset");
    check(overrun, 0, "overrun after reset");
    while (!$feof(fd)) begin
      line = '0;
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %d %d %d %d %h", div_v, bits_v, par_v, stop_v, op_v, data_v);
      if (n == 6) begin  // comment and blank lines fail the scan
        cyc = OVERSAMPLE * (div_v + 1);
        @(posedge clk);
        clock_divider <= div_v[19:0];
        data_len      <= data_len_t'(bits_v - 1);
        parity        <= parity_t'(par_v[1:0]);
        stop          <= (stop_v == 2) ? STOP_TWO : STOP_ONE;
        repeat (2 * cyc) @(posedge clk);
        if (op_v == 0) begin
          run_tx(data_v[7:0], bits_v, par_v, stop_v, cyc);
        end else begin
          run_rx(data_v[7:0], bits_v, par_v, stop_v, cyc, op_v);
        end
      end
    end
    $fclose(fd);
    $display("test passed");
    $finish;
  end

endmodule

// ==== dv/uart_stim.txt ====
# divider(hex) data_bits parity(0 none 1 even 2 odd) stop_bits op data(hex)
# op: 0 tx, 1 rx, 2 rx bad parity, 3 rx bad stop, 4 rx overrun
3 8 0 1 0 a5
3 8 1 1 0 3c
2 7 2 2 0 5b
1 5 1 2 0 17
4 6 2 1 0 c9
3 8 0 1 1 a5
3 8 1 1 1 96
2 7 2 2 1 33
1 5 1 2 1 1e
2 6 2 1 1 f0
3 8 1 1 2 3c
2 7 2 1 2 15
3 8 0 1 3 55
2 8 1 2 3 81
1 5 0 2 3 0a
3 8 0 1 4 c3
2 7 1 2 4 2d

// ==== src.f ====
design/uart_frame_pkg.sv
design/uart_fsm_pkg.sv
design/baud_tick_gen.sv
design/rx_sampler.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_ctrl.sv
dv/tb_clock_gen.sv
dv/tb_uart_ctrl.sv
